// ==== tb.f ====
+incdir+testbench
src/ccu_pkg.sv
src/ccu_arb.sv
src/ccu_biu.sv
src/ccu_line_mem.sv
src/ccu_top.sv
testbench/ccu_tb.sv

// ==== testbench/ccu_tb_model.svh ====
// ---------------------------------------------------------------------
// CCU testbench shadow model
// Last data written to each line and the expected read line
// ---------------------------------------------------------------------

`ifndef CCU_TB_MODEL_SVH
`define CCU_TB_MODEL_SVH

logic [LINE_WIDTH-1:0] shadow_line  [0:2**LINE_ADDR_WIDTH-1];
logic                  line_written [0:2**LINE_ADDR_WIDTH-1];

task automatic clear_model();
    for (int i = 0; i < 2**LINE_ADDR_WIDTH; i++) begin
        shadow_line[i]  = '0;
        line_written[i] = 1'b0;
    end
endtask

// The update lands after the current edge, so a request issued on the
// same edge still sees the state from before this write
task automatic model_write(input logic [LINE_ADDR_WIDTH-1:0] addr,
                           input logic [LINE_WIDTH-1:0]      data);
    shadow_line[addr]  <= data;
    line_written[addr] <= 1'b1;
endtask

// Requests are served one at a time, so the newest write wins
function automatic logic [LINE_WIDTH-1:0] expected_line(
    input logic [LINE_ADDR_WIDTH-1:0] addr);
    return shadow_line[addr];
endfunction

`endif

// ==== testbench/ccu_tb.sv ====
// ---------------------------------------------------------------------
// CCU testbench
// Two random requestors checked against a shadow model of the store
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module ccu_tb import ccu_pkg::*; ();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int REQS_PER_PORT  = 100;
    // Each request needs at most about 20 cycles with both ports contending
    localparam int TIMEOUT_CYCLES = NUM_REQ * REQS_PER_PORT * 20;
    localparam int WR_LATENCY     = 8;
    localparam int RD_LATENCY     = 10;

    logic                  clk;
    logic                  i_rst_n;
    logic [NUM_REQ-1:0]    i_req_valid;
    ccu_req_t              i_req [0:NUM_REQ-1];
    logic [NUM_REQ-1:0]    o_req_grant;
    logic [NUM_REQ-1:0]    o_req_done;
    logic [LINE_WIDTH-1:0] o_req_data;

    integer                seed;
    int                    error_count;
    int                    cycle_count;
    int                    reads_checked;
    int                    latency_checks;
    int                    errors_before;
    int                    done_count [0:NUM_REQ-1];
    logic [NUM_REQ-1:0]    prev_valid;

    logic                  gen_we   [0:NUM_REQ-1][0:REQS_PER_PORT-1];
    logic [2:0]            gen_line [0:NUM_REQ-1][0:REQS_PER_PORT-1];
    logic [LINE_WIDTH-1:0] gen_data [0:NUM_REQ-1][0:REQS_PER_PORT-1];
    int                    gen_gap  [0:NUM_REQ-1][0:REQS_PER_PORT-1];

    `include "ccu_tb_model.svh"

    ccu_top UUT (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_grant (o_req_grant),
        .o_req_done  (o_req_done),
        .o_req_data  (o_req_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic value_error(input string name, input logic [LINE_WIDTH-1:0] got,
                               input logic [LINE_WIDTH-1:0] exp);
        $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic plain_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        $display("Test %s: %s with %0d errors", name,
                 (error_count == errors_at_start) ? "passed" : "failed",
                 error_count - errors_at_start);
    endtask

    function automatic logic [NUM_REQ-1:0] lowest_bit(input logic [NUM_REQ-1:0] vec);
        return vec & (~vec + 1'b1);
    endfunction

    task automatic generate_traffic();
        for (int r = 0; r < NUM_REQ; r++) begin
            for (int n = 0; n < REQS_PER_PORT; n++) begin
                gen_we[r][n]   = $random(seed);
                gen_line[r][n] = $random(seed);
                for (int w = 0; w < LINE_WORDS; w++) begin
                    gen_data[r][n][w*WORD_WIDTH +: WORD_WIDTH] = $random(seed);
                end
                gen_gap[r][n] = 1 + ($unsigned($random(seed)) % 4);
            end
        end
    endtask

    task automatic run_requestor(input int r);
        ccu_req_t              req;
        int                    waited;
        int                    grant_at;
        int                    latency;
        logic [LINE_WIDTH-1:0] exp_line;
        for (int n = 0; n < REQS_PER_PORT; n++) begin
            // Eight lines spread over the whole line address range
            req.addr = {gen_line[r][n], gen_line[r][n]};
            // A read only goes to a line that already holds known data
            req.we   = gen_we[r][n] || !line_written[req.addr];
            req.data = gen_data[r][n];
            i_req[r]       <= req;
            i_req_valid[r] <= 1'b1;
            waited   = 0;
            grant_at = 0;
            do begin
                @(posedge clk);
                waited++;
                if (o_req_grant[r]) begin
                    assert (grant_at == 0)
                        else plain_error($sformatf("requestor %0d granted twice", r));
                    grant_at = waited;
                end
            end while (!o_req_done[r]);
            i_req_valid[r] <= 1'b0;
            assert (grant_at != 0)
                else plain_error($sformatf("requestor %0d got done without a grant", r));
            if (req.we) begin
                model_write(req.addr, req.data);
            end else begin
                exp_line = expected_line(req.addr);
                reads_checked++;
                assert (o_req_data === exp_line)
                    else value_error("o_req_data", o_req_data, exp_line);
            end
            // A grant on the first cycle means the whole pipeline was free
            if (grant_at == 2) begin
                latency = waited - 1;
                latency_checks++;
                assert (latency == (req.we ? WR_LATENCY : RD_LATENCY))
                    else value_error("latency", latency, req.we ? WR_LATENCY : RD_LATENCY);
            end
            repeat (gen_gap[r][n]) begin
                @(posedge clk);
                assert (!o_req_done[r] && !o_req_grant[r])
                    else plain_error($sformatf("requestor %0d saw grant or done while idle", r));
            end
        end
    endtask

    // Grant seen now was decided from the valid vector of the previous edge
    always @(posedge clk) begin
        if (i_rst_n) begin
            assert ($onehot0(o_req_grant) && $onehot0(o_req_done))
                else plain_error("grant or done set for both requestors at once");
            assert ((o_req_grant & ~prev_valid) == '0)
                else plain_error("grant given to a requestor without valid");
            assert (o_req_grant == '0 || o_req_grant == lowest_bit(prev_valid))
                else value_error("o_req_grant", o_req_grant, lowest_bit(prev_valid));
            // Every done pulse counts, even one that no requestor waits for
            for (int r = 0; r < NUM_REQ; r++) begin
                if (o_req_done[r]) begin
                    done_count[r]++;
                end
            end
        end
        prev_valid = i_req_valid;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: traffic still running after %0d cycles", cycle_count);
        $display("Checks failed");
        $finish;
    end

    initial begin
        i_rst_n        = 1'b0;
        i_req_valid    = '0;
        i_req[0]       = '0;
        i_req[1]       = '0;
        prev_valid     = '0;
        seed           = 42909;
        error_count    = 0;
        reads_checked  = 0;
        latency_checks = 0;
        done_count[0]  = 0;
        done_count[1]  = 0;
        clear_model();
        generate_traffic();
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;

        errors_before = error_count;
        repeat (4) begin
            @(posedge clk);
            assert (o_req_grant == '0 && o_req_done == '0)
                else plain_error("grant or done active after reset with no request");
        end
        report_test("reset_idle", errors_before);

        errors_before = error_count;
        fork
            run_requestor(0);
            run_requestor(1);
        join
        assert (latency_checks > 0)
            else plain_error("no uncontended request was seen for the latency check");
        report_test("random_traffic", errors_before);

        errors_before = error_count;
        repeat (8) begin
            @(posedge clk);
            assert (o_req_grant == '0 && o_req_done == '0)
                else plain_error("grant or done active after all requests finished");
        end
        for (int r = 0; r < NUM_REQ; r++) begin
            assert (done_count[r] == REQS_PER_PORT)
                else value_error($sformatf("done_count[%0d]", r), done_count[r], REQS_PER_PORT);
        end
        report_test("final_quiet", errors_before);

        $display("Summary: %0d requests, %0d reads checked, %0d latency checks, %0d errors",
                 done_count[0] + done_count[1], reads_checked, latency_checks, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== src/ccu_top.sv ====
// ---------------------------------------------------------------------
// Core communications unit top
// Arbiter, bus interface unit and line store in one pipeline
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module ccu_top import ccu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,

    input  logic [NUM_REQ-1:0]    i_req_valid,
    input  ccu_req_t              i_req [0:NUM_REQ-1],
    output logic [NUM_REQ-1:0]    o_req_grant,
    output logic [NUM_REQ-1:0]    o_req_done,
    output logic [LINE_WIDTH-1:0] o_req_data
);

    logic                  biu_en;
    biu_cmd_t              biu_cmd;
    logic                  biu_done;
    logic [LINE_WIDTH-1:0] biu_data;
    logic                  beat_valid;
    mem_beat_t             beat;
    logic                  rd_valid;
    logic [WORD_WIDTH-1:0] rd_data;

    ccu_arb u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_grant (o_req_grant),
        .o_req_done  (o_req_done),
        .o_req_data  (o_req_data),
        .o_biu_en    (biu_en),
        .o_biu_cmd   (biu_cmd),
        .i_biu_done  (biu_done),
        .i_biu_data  (biu_data)
    );

    ccu_biu u_biu (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_en         (biu_en),
        .i_cmd        (biu_cmd),
        .o_done       (biu_done),
        .o_data       (biu_data),
        .o_beat_valid (beat_valid),
        .o_beat       (beat),
        .i_rd_valid   (rd_valid),
        .i_rd_data    (rd_data)
    );

    ccu_line_mem u_line_mem (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_beat_valid (beat_valid),
        .i_beat       (beat),
        .o_rd_valid   (rd_valid),
        .o_rd_data    (rd_data)
    );

endmodule

// ==== src/ccu_line_mem.sv ====
// ---------------------------------------------------------------------
// CCU line store
// Word-wide memory with a fixed-latency registered read path
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module ccu_line_mem import ccu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,

    input  logic                  i_beat_valid,
    input  mem_beat_t             i_beat,
    output logic                  o_rd_valid,
    output logic [WORD_WIDTH-1:0] o_rd_data
);

    logic [WORD_WIDTH-1:0]     mem [0:2**WORD_ADDR_WIDTH-1];
    logic [MEM_RD_LATENCY-1:0] rd_valid_q;
    logic [WORD_WIDTH-1:0]     rd_data_q [0:MEM_RD_LATENCY-1];
    logic                      rd_req;

    assign rd_req = i_beat_valid && !i_beat.we;

    // Writes take effect at the end of the beat's own cycle
    always_ff @(posedge clk) begin
        if (i_beat_valid && i_beat.we) begin
            mem[i_beat.addr] <= i_beat.data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q <= {rd_valid_q[MEM_RD_LATENCY-2:0], rd_req};
        end
    end

    // Data stages shift freely; only the valid stages qualify them
    always_ff @(posedge clk) begin
        rd_data_q[0] <= mem[i_beat.addr];
        for (int i = 1; i < MEM_RD_LATENCY; i++) begin
            rd_data_q[i] <= rd_data_q[i-1];
        end
    end

    assign o_rd_valid = rd_valid_q[MEM_RD_LATENCY-1];
    assign o_rd_data  = rd_data_q[MEM_RD_LATENCY-1];

    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_beat_valid |-> !$isunknown(i_beat.addr))
        else $error("ccu_line_mem: beat address is unknown");

endmodule

// ==== src/ccu_biu.sv ====
// ---------------------------------------------------------------------
// CCU bus interface unit
// Splits a line command into word beats and gathers read words back
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module ccu_biu import ccu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,

    input  logic                  i_en,
    input  biu_cmd_t              i_cmd,
    output logic                  o_done,
    output logic [LINE_WIDTH-1:0] o_data,

    output logic                  o_beat_valid,
    output mem_beat_t             o_beat,
    input  logic                  i_rd_valid,
    input  logic [WORD_WIDTH-1:0] i_rd_data
);

    typedef enum logic [2:0] {
        BIU_IDLE,
        BIU_ISSUE,
        BIU_COLLECT,
        BIU_DONE,
        BIU_DRAIN
    } biu_state_e;

    biu_state_e                state_r;
    biu_state_e                state_next;
    biu_cmd_t                  cmd_r;
    logic [BEAT_IDX_WIDTH-1:0] beat_cnt_r;
    logic [BEAT_IDX_WIDTH-1:0] ret_cnt_r;
    logic [LINE_WIDTH-1:0]     line_r;
    logic                      last_beat;
    logic                      last_ret;

    assign last_beat = (beat_cnt_r == BEAT_IDX_WIDTH'(LINE_WORDS - 1));
    assign last_ret  = (ret_cnt_r == BEAT_IDX_WIDTH'(LINE_WORDS - 1));

    always_comb begin
        state_next = state_r;
        case (state_r)
            BIU_IDLE: begin
                if (i_en) begin
                    state_next = BIU_ISSUE;
                end
            end
            BIU_ISSUE: begin
                if (last_beat) begin
                    state_next = (cmd_r.func == BIU_FUNC_WRITE) ? BIU_DONE : BIU_COLLECT;
                end
            end
            BIU_COLLECT: begin
                if (i_rd_valid && last_ret) begin
                    state_next = BIU_DONE;
                end
            end
            BIU_DONE: begin
                state_next = BIU_DRAIN;
            end
            // Hold here while the arbiter still drives enable
            BIU_DRAIN: begin
                if (!i_en) begin
                    state_next = BIU_IDLE;
                end
            end
            default: begin
                state_next = BIU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= BIU_IDLE;
            beat_cnt_r <= '0;
            ret_cnt_r  <= '0;
        end else begin
            state_r <= state_next;
            if (state_r == BIU_IDLE && i_en) begin
                beat_cnt_r <= '0;
                ret_cnt_r  <= '0;
            end else begin
                if (state_r == BIU_ISSUE) begin
                    beat_cnt_r <= beat_cnt_r + 1'b1;
                end
                if (i_rd_valid) begin
                    ret_cnt_r <= ret_cnt_r + 1'b1;
                end
            end
        end
    end

    // Read words come back in issue order, so the return count is the slot
    always_ff @(posedge clk) begin
        if (state_r == BIU_IDLE && i_en) begin
            cmd_r <= i_cmd;
        end
        if (i_rd_valid) begin
            line_r[ret_cnt_r * WORD_WIDTH +: WORD_WIDTH] <= i_rd_data;
        end
    end

    assign o_done       = (state_r == BIU_DONE);
    assign o_data       = line_r;
    assign o_beat_valid = (state_r == BIU_ISSUE);
    assign o_beat.we    = (cmd_r.func == BIU_FUNC_WRITE);
    assign o_beat.addr  = {cmd_r.addr, beat_cnt_r};
    assign o_beat.data  = cmd_r.data[beat_cnt_r * WORD_WIDTH +: WORD_WIDTH];

    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rd_valid |-> (state_r != BIU_IDLE))
        else $error("ccu_biu: read data returned with no transaction open");

    // The store must answer each read beat after exactly the fixed latency
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_beat_valid && !o_beat.we) |-> ##MEM_RD_LATENCY i_rd_valid)
        else $error("ccu_biu: read word missing at the expected cycle");

endmodule

// ==== src/ccu_arb.sv ====
// ---------------------------------------------------------------------
// CCU arbiter
// Fixed-priority pick of one line request, forwarded to the BIU
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module ccu_arb import ccu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,

    // Requestor side
    input  logic [NUM_REQ-1:0]    i_req_valid,
    input  ccu_req_t              i_req [0:NUM_REQ-1],
    output logic [NUM_REQ-1:0]    o_req_grant,
    output logic [NUM_REQ-1:0]    o_req_done,
    output logic [LINE_WIDTH-1:0] o_req_data,

    // BIU side
    output logic                  o_biu_en,
    output biu_cmd_t              o_biu_cmd,
    input  logic                  i_biu_done,
    input  logic [LINE_WIDTH-1:0] i_biu_data
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_DONE
    } arb_state_e;

    arb_state_e               state_r;
    arb_state_e               state_next;
    logic [REQ_IDX_WIDTH-1:0] pick_idx;
    logic [REQ_IDX_WIDTH-1:0] idx_r;
    logic                     any_valid;
    logic [NUM_REQ-1:0]       grant_next;
    logic [NUM_REQ-1:0]       done_next;
    logic                     biu_en_next;
    logic [NUM_REQ-1:0]       granted_r;

    // Lowest valid index wins, so scan from the top down
    always_comb begin
        pick_idx  = '0;
        any_valid = 1'b0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (i_req_valid[i]) begin
                pick_idx  = REQ_IDX_WIDTH'(i);
                any_valid = 1'b1;
            end
        end
    end

    // The winner is captured only while idle and held for the whole transaction
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx_r <= '0;
        end else if (state_r == ARB_IDLE) begin
            idx_r <= pick_idx;
        end
    end

    always_comb begin
        state_next  = state_r;
        grant_next  = '0;
        done_next   = '0;
        biu_en_next = 1'b0;
        case (state_r)
            ARB_IDLE: begin
                if (any_valid) begin
                    grant_next[pick_idx] = 1'b1;
                    state_next           = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                // BIU enable tracks the winner's valid, one cycle behind
                biu_en_next      = i_req_valid[idx_r];
                done_next[idx_r] = i_biu_done;
                if (i_biu_done) begin
                    state_next = ARB_DONE;
                end
            end
            ARB_DONE: begin
                state_next = ARB_IDLE;
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= ARB_IDLE;
            o_req_grant <= '0;
            o_req_done  <= '0;
            o_biu_en    <= 1'b0;
        end else begin
            state_r     <= state_next;
            o_req_grant <= grant_next;
            o_req_done  <= done_next;
            o_biu_en    <= biu_en_next;
        end
    end

    // Command follows the latched winner every cycle
    always_ff @(posedge clk) begin
        o_biu_cmd.func <= i_req[idx_r].we ? BIU_FUNC_WRITE : BIU_FUNC_READ;
        o_biu_cmd.addr <= i_req[idx_r].addr;
        o_biu_cmd.data <= i_req[idx_r].data;
        o_req_data     <= i_biu_data;
    end

    // Grant that opened the transaction in flight
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            granted_r <= '0;
        end else if (|o_req_grant) begin
            granted_r <= o_req_grant;
        end
    end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(o_req_grant | o_req_done))
        else $error("ccu_arb: grant and done overlap or have more than one bit set");

    // Done must land on the requestor that won the arbitration
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (|o_req_done) |-> (o_req_done == granted_r))
        else $error("ccu_arb: done sent to a requestor that was not granted");

endmodule

// ==== src/ccu_pkg.sv ====
// ---------------------------------------------------------------------
// Core communications unit package
// Sizes, BIU function codes and the structs shared by all stages
// ---------------------------------------------------------------------

package ccu_pkg;

    localparam int NUM_REQ         = 2;
    localparam int REQ_IDX_WIDTH   = $clog2(NUM_REQ);
    localparam int LINE_ADDR_WIDTH = 6;
    localparam int WORD_WIDTH      = 32;
    localparam int LINE_WORDS      = 4;
    localparam int LINE_WIDTH      = LINE_WORDS * WORD_WIDTH;
    localparam int BEAT_IDX_WIDTH  = $clog2(LINE_WORDS);
    localparam int WORD_ADDR_WIDTH = LINE_ADDR_WIDTH + BEAT_IDX_WIDTH;
    localparam int MEM_RD_LATENCY  = 2;

    typedef enum logic {
        BIU_FUNC_READ  = 1'b0,
        BIU_FUNC_WRITE = 1'b1
    } biu_func_e;

    // One line request as presented by a requestor
    typedef struct packed {
        logic                       we;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
    } ccu_req_t;

    typedef struct packed {
        biu_func_e                  func;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
    } biu_cmd_t;

    // A single word access toward the line store
    typedef struct packed {
        logic                       we;
        logic [WORD_ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0]      data;
    } mem_beat_t;

endpackage
